/* design/fpAddPkg.sv */
// Shared widths, field types and stage structs for the pipelined single-precision adder
`default_nettype none

package fpAddPkg;

    // IEEE-754 single precision field sizes
    localparam int expWidth = 8;
    localparam int fracWidth = 23;
    localparam int expMax = 255;

    // Mantissa bits plus guard and round
    // Also the alignment shift at which only sticky is left
    localparam int alignLimit = fracWidth + 3;

    typedef logic [31:0] floatWord;
    typedef logic [expWidth-1:0] expField;
    typedef logic [fracWidth-1:0] fracField;

    // Fraction with the implicit one in front
    typedef logic [fracWidth:0] mantissa;

    // Alignment shift or leading-zero count
    typedef logic [4:0] shiftCount;

    // Operation as presented at the top level
    typedef struct packed {
        floatWord a;
        floatWord b;
        logic     sub;
    } fpOperands;

    // Align stage output
    typedef struct packed {
        logic    valid;
        mantissa largeMant;
        mantissa smallMant;
        expField largeExp;
        logic    largeSign;
        logic    effSub;
        logic    guardBit;
        logic    roundBit;
        logic    stickyBit;
    } alignedOps;

    // Add stage output, feeds normalize and round
    typedef struct packed {
        logic    valid;
        mantissa alignedResult;
        logic    carryOut;
        expField exponentOut;
        logic    alignedSign;
        logic    guardBit;
        logic    roundBit;
        logic    stickyBit;
    } sumResult;

endpackage

`default_nettype wire

/* design/fpAlign.sv */
// First adder stage that unpacks, orders and aligns both operands, registered once
`default_nettype none
`timescale 1ns/1ps

module fpAlign (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  fpAddPkg::fpOperands  ops,
    output fpAddPkg::alignedOps  aligned
);
    import fpAddPkg::*;

    expField   expA;
    expField   expB;
    fracField  fracA;
    fracField  fracB;
    mantissa   mantA;
    mantissa   mantB;
    logic      signA;
    logic      signB;
    logic      aIsLarger;

    expField   largeExp;
    expField   smallExp;
    mantissa   largeMant;
    mantissa   smallMant;
    expField   expDiff;
    shiftCount shiftAmt;

    // Smaller mantissa followed by room for every bit shifted out
    logic [fracWidth+alignLimit:0] shiftBuf;

    alignedOps alignedNext;

    // Unpack fields, zero exponent flushes to zero
    always_comb
    begin
        expA  = ops.a[fracWidth+expWidth-1:fracWidth];
        expB  = ops.b[fracWidth+expWidth-1:fracWidth];
        fracA = ops.a[fracWidth-1:0];
        fracB = ops.b[fracWidth-1:0];
        signA = ops.a[fracWidth+expWidth];
        // Subtract is an add with B negated
        signB = ops.b[fracWidth+expWidth] ^ ops.sub;

        mantA = (expA == '0) ? '0 : {1'b1, fracA};
        mantB = (expB == '0) ? '0 : {1'b1, fracB};
    end

    // Order by exponent first, then by mantissa
    always_comb
    begin
        aIsLarger = (expA > expB) || ((expA == expB) && (mantA >= mantB));

        if (aIsLarger)
        begin
            largeExp  = expA;
            smallExp  = expB;
            largeMant = mantA;
            smallMant = mantB;
        end
        else
        begin
            largeExp  = expB;
            smallExp  = expA;
            largeMant = mantB;
            smallMant = mantA;
        end
    end

    // Right shift of the smaller mantissa
    always_comb
    begin
        expDiff = largeExp - smallExp;

        // Past alignLimit every bit lands in sticky anyway
        if (expDiff >= alignLimit)
            shiftAmt = shiftCount'(alignLimit);
        else
            shiftAmt = shiftCount'(expDiff);

        shiftBuf = {smallMant, {alignLimit{1'b0}}} >> shiftAmt;
    end

    always_comb
    begin
        alignedNext.valid     = inValid;
        alignedNext.largeMant = largeMant;
        alignedNext.smallMant = shiftBuf[fracWidth+alignLimit:alignLimit];
        alignedNext.largeExp  = largeExp;
        alignedNext.largeSign = aIsLarger ? signA : signB;
        alignedNext.effSub    = signA ^ signB;

        // First two bits out are guard and round, the rest fold into sticky
        alignedNext.guardBit  = shiftBuf[alignLimit-1];
        alignedNext.roundBit  = shiftBuf[alignLimit-2];
        alignedNext.stickyBit = |shiftBuf[alignLimit-3:0];
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            aligned <= '0;
        else
            aligned <= alignedNext;
    end

endmodule

`default_nettype wire

/* design/fpMantAdd.sv */
// Second adder stage that adds or subtracts the aligned mantissas, registered once
`default_nettype none
`timescale 1ns/1ps

module fpMantAdd (
    input  logic                 clk,
    input  logic                 rstN,
    input  fpAddPkg::alignedOps  aligned,
    output fpAddPkg::sumResult   sum
);
    import fpAddPkg::*;

    // Carry position, mantissa, then guard, round and sticky
    logic [fracWidth+4:0] largeExt;
    logic [fracWidth+4:0] smallExt;
    logic [fracWidth+4:0] total;
    logic                 cancelled;

    sumResult sumNext;

    always_comb
    begin
        largeExt = {1'b0, aligned.largeMant, 3'b000};
        smallExt = {1'b0, aligned.smallMant, aligned.guardBit, aligned.roundBit,
                    aligned.stickyBit};

        // The larger magnitude is always the minuend, so no sign flip here
        // Borrow runs through the guard, round and sticky bits as well
        if (aligned.effSub)
            total = largeExt - smallExt;
        else
            total = largeExt + smallExt;

        cancelled = aligned.effSub && (total == '0);
    end

    always_comb
    begin
        sumNext.valid         = aligned.valid;
        sumNext.alignedResult = total[fracWidth+3:3];
        sumNext.carryOut      = total[fracWidth+4];
        sumNext.exponentOut   = aligned.largeExp;
        // Exact cancellation always yields +0
        sumNext.alignedSign   = cancelled ? 1'b0 : aligned.largeSign;
        sumNext.guardBit      = total[2];
        sumNext.roundBit      = total[1];
        sumNext.stickyBit     = total[0];
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            sum <= '0;
        else
            sum <= sumNext;
    end

endmodule

`default_nettype wire

/* design/fpNormalize.sv */
// Last adder stage that renormalizes, rounds to nearest even and packs the result
`default_nettype none
`timescale 1ns/1ps

module fpNormalize (
    input  logic                clk,
    input  logic                rstN,
    input  fpAddPkg::sumResult  sum,
    output logic                outValid,
    output fpAddPkg::floatWord  result
);
    import fpAddPkg::*;

    shiftCount                   lzCount;
    logic                        isZero;
    logic [fracWidth+3:0]        normBits;
    logic signed [expWidth+1:0]  expWork;
    logic                        roundUp;
    logic [fracWidth+1:0]        roundedMant;
    fracField                    fracOut;
    floatWord                    resultNext;

    // Leading zeros over mantissa, guard and round
    function automatic shiftCount countZeros(input logic [alignLimit-1:0] bits);
        shiftCount count;
        logic      found;
        count = shiftCount'(alignLimit);
        found = 1'b0;
        for (int i = alignLimit - 1; i >= 0; i--)
        begin
            if (!found && bits[i])
            begin
                count = shiftCount'(alignLimit - 1 - i);
                found = 1'b1;
            end
        end
        return count;
    endfunction

    always_comb
    begin
        lzCount = countZeros({sum.alignedResult, sum.guardBit, sum.roundBit});
        isZero  = !sum.carryOut && (sum.alignedResult == '0) && !sum.guardBit &&
                  !sum.roundBit && !sum.stickyBit;

        if (sum.carryOut)
        begin
            // One step right, the lost LSB becomes guard
            normBits = {sum.carryOut, sum.alignedResult, sum.guardBit,
                        sum.roundBit | sum.stickyBit};
            expWork  = $signed({2'b00, sum.exponentOut}) + 10'sd1;
        end
        else
        begin
            // Guard and round shift in behind the mantissa
            normBits = {sum.alignedResult, sum.guardBit, sum.roundBit, sum.stickyBit}
                       << lzCount;
            expWork  = $signed({2'b00, sum.exponentOut}) - $signed({5'b00000, lzCount});
        end

        // Nearest even, ties go to an even LSB
        roundUp     = normBits[2] & (normBits[1] | normBits[0] | normBits[3]);
        roundedMant = {1'b0, normBits[fracWidth+3:3]} + {{(fracWidth+1){1'b0}}, roundUp};

        // A rounding carry leaves only zeros below the new leading one
        fracOut = roundedMant[fracWidth-1:0];

        if (isZero)
            resultNext = {sum.alignedSign, {expWidth{1'b0}}, {fracWidth{1'b0}}};
        else if (expWork <= 0)
            // Underflow is checked before rounding
            resultNext = {sum.alignedSign, {expWidth{1'b0}}, {fracWidth{1'b0}}};
        else if ((expWork + (roundedMant[fracWidth+1] ? 10'sd1 : 10'sd0)) >= expMax)
            resultNext = {sum.alignedSign, {expWidth{1'b1}}, {fracWidth{1'b0}}};
        else
            resultNext = {sum.alignedSign,
                          expField'(expWork + (roundedMant[fracWidth+1] ? 10'sd1 : 10'sd0)),
                          fracOut};
    end

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
            result   <= '0;
        end
        else
        begin
            outValid <= sum.valid;
            result   <= resultNext;
        end
    end

endmodule

`default_nettype wire

/* design/fpAddTop.sv */
// Top of the three-stage floating-point adder, three cycles from input to result
`default_nettype none
`timescale 1ns/1ps

module fpAddTop (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 inValid,
    input  fpAddPkg::fpOperands  ops,
    output logic                 outValid,
    output fpAddPkg::floatWord   result
);
    import fpAddPkg::*;

    // Stage boundaries, each struct carries its own valid
    alignedOps alignedStage;
    sumResult  sumStage;

    // Unpack, swap and align
    fpAlign uAlign (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .ops     (ops),
        .aligned (alignedStage)
    );

    // Mantissa add or subtract
    fpMantAdd uMantAdd (
        .clk     (clk),
        .rstN    (rstN),
        .aligned (alignedStage),
        .sum     (sumStage)
    );

    // Renormalize, round and pack
    fpNormalize uNormalize (
        .clk      (clk),
        .rstN     (rstN),
        .sum      (sumStage),
        .outValid (outValid),
        .result   (result)
    );

endmodule

`default_nettype wire

/* tb/fpAddTb.sv */
// Testbench for the pipelined adder, drives vectors from the testdata file and checks results
`default_nettype none
`timescale 1ns/1ps

module fpAddTb;
    import fpAddPkg::*;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 5;
    localparam int latency = 3;
    localparam int maxIdle = 2;
    localparam int cyclesPerVector = 1 + maxIdle;
    localparam int maxVectors = 64;
    localparam int wordsPerVector = 4;

    // One operation in flight, with the cycle it must come out
    typedef struct packed {
        floatWord expected;
        int       dueCycle;
        int       index;
    } pendingResult;

    logic      clk;
    logic      rstN;
    logic      inValid;
    fpOperands ops;
    logic      outValid;
    floatWord  result;

    logic [31:0]  vectorWords [0:maxVectors*wordsPerVector-1];
    int           vectorCount;
    logic         loadDone;
    int           cycleCount;
    int           errorCount;
    int           checkCount;
    pendingResult pendingQ[$];

    fpAddTop UUT (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .ops      (ops),
        .outValid (outValid),
        .result   (result)
    );

    always #(clkPeriod/2) clk = ~clk;

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    // Unused slots keep a sub column above 1, which marks the end of the data
    task automatic loadVectors();
        for (int i = 0; i < maxVectors*wordsPerVector; i++)
            vectorWords[i] = 32'hEE000000 | 32'(i);
        $readmemh("tb/fpAddTestdata.hex", vectorWords);
        vectorCount = 0;
        while (vectorCount < maxVectors &&
               vectorWords[vectorCount*wordsPerVector+2] <= 32'd1)
            vectorCount++;
    endtask

    task automatic driveVector(input int idx);
        pendingResult entry;
        ops.a   = vectorWords[idx*wordsPerVector];
        ops.b   = vectorWords[idx*wordsPerVector+1];
        ops.sub = vectorWords[idx*wordsPerVector+2][0];
        inValid = 1'b1;
        // Out on the third rising edge after it is driven
        entry.expected = vectorWords[idx*wordsPerVector+3];
        entry.dueCycle = cycleCount + latency;
        entry.index    = idx;
        pendingQ.push_back(entry);
    endtask

    initial
    begin
        int idleCycles;
        clk        = 1'b0;
        rstN       = 1'b0;
        inValid    = 1'b0;
        ops        = '0;
        cycleCount = 0;
        errorCount = 0;
        checkCount = 0;
        loadDone   = 1'b0;
        void'($urandom(58422));

        loadVectors();
        loadDone = 1'b1;
        if (vectorCount == 0)
        begin
            errorCount++;
            $display("No vectors could be read from the data file");
        end

        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        for (int i = 0; i < vectorCount; i++)
        begin
            driveVector(i);
            @(negedge clk);
            // Occasional bubble between operations
            if (($urandom % 4) == 0)
            begin
                inValid    = 1'b0;
                idleCycles = 1 + int'($urandom % maxIdle);
                repeat (idleCycles) @(negedge clk);
            end
        end
        inValid = 1'b0;

        while (pendingQ.size() != 0)
            @(negedge clk);
        // A few more cycles to catch a stray outValid
        repeat (latency + 1) @(negedge clk);

        if (checkCount != vectorCount)
        begin
            errorCount++;
            $display("Only %0d of %0d results came out", checkCount, vectorCount);
        end

        $display("Checked %0d results from %0d vectors, %0d errors",
                 checkCount, vectorCount, errorCount);
        if (errorCount == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Output side, sampled half a cycle after the registers load
    always @(negedge clk)
    begin
        pendingResult head;
        if (!rstN)
        begin
            if (outValid !== 1'b0)
            begin
                errorCount++;
                $display("outValid was high while reset was asserted");
            end
        end
        else if (outValid)
        begin
            if (pendingQ.size() == 0)
            begin
                errorCount++;
                $display("outValid went high at cycle %0d with nothing in flight", cycleCount);
            end
            else
            begin
                head = pendingQ.pop_front();
                checkCount++;
                if (result !== head.expected)
                begin
                    errorCount++;
                    $display("** Error: result got 0x%08h expected 0x%08h (vector %0d)",
                             result, head.expected, head.index);
                end
                if (cycleCount != head.dueCycle)
                begin
                    errorCount++;
                    $display("Result of vector %0d came out at cycle %0d instead of cycle %0d",
                             head.index, cycleCount, head.dueCycle);
                end
            end
        end
    end

    // Watchdog sized from the number of vectors
    initial
    begin
        int timeoutCycles;
        wait (loadDone);
        timeoutCycles = 2 * vectorCount * cyclesPerVector + resetCycles + latency;
        #(timeoutCycles * clkPeriod);
        $display("Timed out at cycle %0d with %0d results still outstanding",
                 cycleCount, pendingQ.size());
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* fpAddTop.f */
design/fpAddPkg.sv
design/fpAlign.sv
design/fpMantAdd.sv
design/fpNormalize.sv
design/fpAddTop.sv
tb/fpAddTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

logFile=sim.log
buildDir=obj_dir

verilator --binary --timing --top-module fpAddTb -f fpAddTop.f \
    --Mdir "$buildDir" -o fpAddSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/fpAddSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "Some tests failed" "$logFile"; then
    exit 1
fi

exit 0

/* tb/fpAddTestdata.hex */
// Columns: operand A, operand B, subtract bit (1 means A minus B), expected result
// One operation per line, all values in hex
3F800000 3F800000 0 40000000
3FC00000 3FC00000 0 40400000
3F800000 40000000 0 40400000
41200000 3F000000 0 41280000
40400000 3F800000 1 40000000
3F800000 3F800000 1 00000000
BF800000 BF800000 1 00000000
00000000 40A00000 0 40A00000
40A00000 00000000 1 40A00000
3F800000 3F000000 1 3F000000
3F800001 3F800000 1 34000000
C0400000 3F800000 0 C0000000
40000000 40400000 1 BF800000
40A00000 41200000 1 C0A00000
// Ties, sticky and rounding carry
3F800000 33800000 0 3F800000
3F800001 33800000 0 3F800002
3F800000 33C00000 0 3F800001
3FFFFFFF 33800000 0 40000000
3F800000 3F800001 0 40000000
3F800001 3F800002 0 40000002
3F800000 33000000 1 3F800000
3F800000 33400000 1 3F7FFFFF
// Overflow, underflow and flushed subnormals
7F7FFFFF 7F7FFFFF 0 7F800000
FF7FFFFF FF7FFFFF 0 FF800000
7F7FFFFF 73000000 0 7F800000
FF7FFFFF 7F7FFFFF 1 FF800000
00800001 00800000 1 00000000
80800001 80800000 1 80000000
01000000 00C00000 1 00000000
807FFFFF 40000000 1 C0000000
00400000 00400000 0 00000000
80000000 80000000 0 80000000
